/* hdl/dcache_types_pkg.sv */
package dcache_types_pkg;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // same width as the pipeline's exception code
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ALE  = 7'h09   // address not aligned
    } exc_code_e;

    typedef enum logic [2:0] {
        ST_IDLE         = 3'd0,
        ST_LOOKUP       = 3'd1,
        ST_WBACK        = 3'd2,  // dirty victim out
        ST_REFILL_WAIT  = 3'd3,
        ST_REFILL_WRITE = 3'd4
    } exec_state_e;

endpackage

/* hdl/mem_bus_pkg.sv */
package mem_bus_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int STRB_WIDTH = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // default geometry of 16 sets with 4-word lines
    localparam int DEF_INDEX_WIDTH       = 4;
    localparam int DEF_WORD_OFFSET_WIDTH = 2;

    localparam int DEF_REQ_DEPTH = 2;  // request queue entries

endpackage

/* hdl/req_decode.sv */
`timescale 1ns/1ps

module req_decode #(
    parameter int INDEX_WIDTH       = mem_bus_pkg::DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = mem_bus_pkg::DEF_WORD_OFFSET_WIDTH,
    parameter int REQ_DEPTH         = mem_bus_pkg::DEF_REQ_DEPTH,
    localparam int TAG_WIDTH = mem_bus_pkg::ADDR_WIDTH - INDEX_WIDTH - WORD_OFFSET_WIDTH - 2
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_req_valid,
    input  dcache_types_pkg::mem_op_e       i_req_op,
    input  dcache_types_pkg::access_size_e  i_req_size,
    input  logic                            i_req_signed,
    input  mem_bus_pkg::addr_t              i_req_addr,
    input  mem_bus_pkg::word_t              i_req_wdata,
    output logic                            o_req_credit,
    input  logic                            i_pop_ready,
    output logic                            o_dec_valid,
    output dcache_types_pkg::mem_op_e       o_dec_op,
    output dcache_types_pkg::access_size_e  o_dec_size,
    output logic                            o_dec_signed,
    output logic [INDEX_WIDTH-1:0]          o_dec_index,
    output logic [TAG_WIDTH-1:0]            o_dec_tag,
    output logic [WORD_OFFSET_WIDTH-1:0]    o_dec_word_off,
    output logic [1:0]                      o_dec_byte_off,
    output mem_bus_pkg::word_t              o_dec_wdata,
    output logic                            o_dec_misaligned
);
    import dcache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int PTR_WIDTH = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(REQ_DEPTH + 1);
    localparam int OFF_WIDTH = WORD_OFFSET_WIDTH + 2;

    // raw request storage
    mem_op_e      op_mem   [REQ_DEPTH];
    access_size_e size_mem [REQ_DEPTH];
    logic         sign_mem [REQ_DEPTH];
    addr_t        addr_mem [REQ_DEPTH];
    word_t        wdata_mem[REQ_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr, rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 pop;
    addr_t                head_addr;

    assign pop = o_dec_valid && i_pop_ready;

    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            op_mem[wr_ptr]    <= i_req_op;
            size_mem[wr_ptr]  <= i_req_size;
            sign_mem[wr_ptr]  <= i_req_signed;
            addr_mem[wr_ptr]  <= i_req_addr;
            wdata_mem[wr_ptr] <= i_req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            o_req_credit <= 1'b0;
        end else begin
            if (i_req_valid)  // sender holds a credit, so no overflow
                wr_ptr <= (wr_ptr == PTR_WIDTH'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_WIDTH'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count        <= count + CNT_WIDTH'(i_req_valid) - CNT_WIDTH'(pop);
            o_req_credit <= pop;  // entry freed, hand the credit back
        end
    end

    assign head_addr   = addr_mem[rd_ptr];
    assign o_dec_valid = (count != '0);

    // field split of the head entry
    assign o_dec_op       = op_mem[rd_ptr];
    assign o_dec_size     = size_mem[rd_ptr];
    assign o_dec_signed   = sign_mem[rd_ptr];
    assign o_dec_wdata    = wdata_mem[rd_ptr];
    assign o_dec_byte_off = head_addr[1:0];
    assign o_dec_word_off = head_addr[OFF_WIDTH-1:2];
    assign o_dec_index    = head_addr[OFF_WIDTH+INDEX_WIDTH-1:OFF_WIDTH];
    assign o_dec_tag      = head_addr[ADDR_WIDTH-1:OFF_WIDTH+INDEX_WIDTH];

    always_comb begin
        case (o_dec_size)
            SIZE_HALF: o_dec_misaligned = head_addr[0];
            SIZE_WORD: o_dec_misaligned = (head_addr[1:0] != 2'b00);
            default:   o_dec_misaligned = 1'b0;
        endcase
    end

endmodule

/* hdl/cache_exec.sv */
`timescale 1ns/1ps

module cache_exec #(
    parameter int INDEX_WIDTH       = mem_bus_pkg::DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = mem_bus_pkg::DEF_WORD_OFFSET_WIDTH,
    localparam int TAG_WIDTH  = mem_bus_pkg::ADDR_WIDTH - INDEX_WIDTH - WORD_OFFSET_WIDTH - 2,
    localparam int LINE_WIDTH = mem_bus_pkg::WORD_WIDTH << WORD_OFFSET_WIDTH
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_dec_valid,
    input  dcache_types_pkg::mem_op_e       i_dec_op,
    input  dcache_types_pkg::access_size_e  i_dec_size,
    input  logic                            i_dec_signed,
    input  logic [INDEX_WIDTH-1:0]          i_dec_index,
    input  logic [TAG_WIDTH-1:0]            i_dec_tag,
    input  logic [WORD_OFFSET_WIDTH-1:0]    i_dec_word_off,
    input  logic [1:0]                      i_dec_byte_off,
    input  mem_bus_pkg::word_t              i_dec_wdata,
    input  logic                            i_dec_misaligned,
    output logic                            o_pop_ready,
    output logic                            o_acc_valid,
    output dcache_types_pkg::mem_op_e       o_acc_op,
    output dcache_types_pkg::access_size_e  o_acc_size,
    output logic                            o_acc_signed,
    output logic [1:0]                      o_acc_byte_off,
    output logic                            o_acc_misaligned,
    output mem_bus_pkg::word_t              o_acc_word,
    output logic                            o_mem_rvalid,
    output mem_bus_pkg::addr_t              o_mem_raddr,
    input  logic                            i_mem_rready,
    input  logic [LINE_WIDTH-1:0]           i_mem_rdata,
    output logic                            o_mem_wvalid,
    output mem_bus_pkg::addr_t              o_mem_waddr,
    output logic [LINE_WIDTH-1:0]           o_mem_wdata,
    input  logic                            i_mem_wready
);
    import dcache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int SETS = 1 << INDEX_WIDTH;
    localparam int OFF_WIDTH = WORD_OFFSET_WIDTH + 2;

    exec_state_e state, state_nx;

    // arrays for two ways
    logic [TAG_WIDTH-1:0]  tag_q  [2][SETS];
    logic [LINE_WIDTH-1:0] data_q [2][SETS];
    logic [1:0][SETS-1:0]  valid_q;
    logic [1:0][SETS-1:0]  dirty_q;
    logic [SETS-1:0]       lru_q;  // way to evict next

    // request under service
    mem_op_e                op_q;
    access_size_e           size_q;
    logic                   signed_q;
    logic [INDEX_WIDTH-1:0] index_q;
    logic [TAG_WIDTH-1:0]   tag_q_req;
    logic [WORD_OFFSET_WIDTH-1:0] word_off_q;
    logic [1:0]             byte_off_q;
    word_t                  wdata_q;
    logic                   misaligned_q;

    logic [LINE_WIDTH-1:0] refill_q;
    logic [1:0]            hit;
    logic                  hit_way, victim, victim_dirty, line_we, way_sel;
    logic [LINE_WIDTH-1:0] base_line, line_wdata;
    word_t                 old_word, merged_word, wdata_sh;
    strb_t                 strb;

    assign o_pop_ready = (state == ST_IDLE);

    always_ff @(posedge clk) begin
        if (o_pop_ready && i_dec_valid) begin
            op_q         <= i_dec_op;
            size_q       <= i_dec_size;
            signed_q     <= i_dec_signed;
            index_q      <= i_dec_index;
            tag_q_req    <= i_dec_tag;
            word_off_q   <= i_dec_word_off;
            byte_off_q   <= i_dec_byte_off;
            wdata_q      <= i_dec_wdata;
            misaligned_q <= i_dec_misaligned;
        end
        if (o_mem_rvalid && i_mem_rready)
            refill_q <= i_mem_rdata;
    end

    // tag compare
    assign hit[0]  = valid_q[0][index_q] && (tag_q[0][index_q] == tag_q_req);
    assign hit[1]  = valid_q[1][index_q] && (tag_q[1][index_q] == tag_q_req);
    assign hit_way = hit[1];
    assign victim  = lru_q[index_q];
    assign victim_dirty = valid_q[victim][index_q] && dirty_q[victim][index_q];

    assign way_sel   = (state == ST_REFILL_WRITE) ? victim : hit_way;
    assign base_line = (state == ST_REFILL_WRITE) ? refill_q : data_q[hit_way][index_q];
    assign old_word  = base_line[word_off_q*WORD_WIDTH +: WORD_WIDTH];
    assign wdata_sh  = wdata_q << {byte_off_q, 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: strb = strb_t'(4'b0001 << byte_off_q);
            SIZE_HALF: strb = strb_t'(4'b0011 << byte_off_q);
            default:   strb = '1;
        endcase
    end

    // store merge into the selected word of the line
    always_comb begin
        merged_word = old_word;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b])
                merged_word[b*8 +: 8] = wdata_sh[b*8 +: 8];
        end
        line_wdata = base_line;
        if (op_q == OP_STORE)
            line_wdata[word_off_q*WORD_WIDTH +: WORD_WIDTH] = merged_word;
    end

    assign line_we = (state == ST_REFILL_WRITE) ||
                     (state == ST_LOOKUP && |hit && !misaligned_q && op_q == OP_STORE);

    always_ff @(posedge clk) begin
        if (line_we)
            data_q[way_sel][index_q] <= line_wdata;
        if (state == ST_REFILL_WRITE)
            tag_q[victim][index_q] <= tag_q_req;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= ST_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            state <= state_nx;
            if (state == ST_LOOKUP && |hit && !misaligned_q) begin
                lru_q[index_q] <= ~hit_way;
                if (op_q == OP_STORE)
                    dirty_q[hit_way][index_q] <= 1'b1;
            end
            if (state == ST_REFILL_WRITE) begin
                lru_q[index_q]            <= ~victim;
                valid_q[victim][index_q]  <= 1'b1;
                dirty_q[victim][index_q]  <= (op_q == OP_STORE);
            end
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE:         if (i_dec_valid) state_nx = ST_LOOKUP;
            ST_LOOKUP: begin
                if (misaligned_q || |hit)
                    state_nx = ST_IDLE;
                else
                    state_nx = victim_dirty ? ST_WBACK : ST_REFILL_WAIT;
            end
            ST_WBACK:        if (i_mem_wready) state_nx = ST_REFILL_WAIT;
            ST_REFILL_WAIT:  if (i_mem_rready) state_nx = ST_REFILL_WRITE;
            ST_REFILL_WRITE: state_nx = ST_IDLE;
            default:         state_nx = ST_IDLE;
        endcase
    end

    // payload stays stable while the FSM waits on memory
    assign o_mem_wvalid = (state == ST_WBACK);
    assign o_mem_waddr  = {tag_q[victim][index_q], index_q, {OFF_WIDTH{1'b0}}};
    assign o_mem_wdata  = data_q[victim][index_q];
    assign o_mem_rvalid = (state == ST_REFILL_WAIT);
    assign o_mem_raddr  = {tag_q_req, index_q, {OFF_WIDTH{1'b0}}};

    // finished access
    assign o_acc_valid = (state == ST_LOOKUP && (misaligned_q || |hit)) ||
                         (state == ST_REFILL_WRITE);
    assign o_acc_op         = op_q;
    assign o_acc_size       = size_q;
    assign o_acc_signed     = signed_q;
    assign o_acc_byte_off   = byte_off_q;
    assign o_acc_misaligned = misaligned_q;
    assign o_acc_word       = old_word;

endmodule

/* hdl/load_result.sv */
`timescale 1ns/1ps

module load_result (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_acc_valid,
    input  dcache_types_pkg::mem_op_e       i_acc_op,
    input  dcache_types_pkg::access_size_e  i_acc_size,
    input  logic                            i_acc_signed,
    input  logic [1:0]                      i_acc_byte_off,
    input  logic                            i_acc_misaligned,
    input  mem_bus_pkg::word_t              i_acc_word,
    output logic                            o_resp_valid,
    output mem_bus_pkg::word_t              o_resp_data,
    output dcache_types_pkg::exc_code_e     o_resp_exc
);
    import dcache_types_pkg::*;
    import mem_bus_pkg::*;

    word_t     shifted, data_nx;
    exc_code_e exc_nx;

    assign shifted = i_acc_word >> {i_acc_byte_off, 3'b000};  // wanted bytes to the bottom

    always_comb begin
        exc_nx = EXC_NONE;
        case (i_acc_size)
            SIZE_BYTE: data_nx = {{24{i_acc_signed & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: data_nx = {{16{i_acc_signed & shifted[15]}}, shifted[15:0]};
            default:   data_nx = i_acc_word;
        endcase
        if (i_acc_misaligned) begin
            data_nx = '0;
            exc_nx  = EXC_ALE;
        end else if (i_acc_op == OP_STORE) begin
            data_nx = '0;  // stores answer with zero
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            o_resp_valid <= 1'b0;
        else
            o_resp_valid <= i_acc_valid;
    end

    always_ff @(posedge clk) begin
        if (i_acc_valid) begin
            o_resp_data <= data_nx;
            o_resp_exc  <= exc_nx;
        end
    end

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_WIDTH       = mem_bus_pkg::DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = mem_bus_pkg::DEF_WORD_OFFSET_WIDTH,
    parameter int REQ_DEPTH         = mem_bus_pkg::DEF_REQ_DEPTH
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_req_valid,
    input  dcache_types_pkg::mem_op_e       i_req_op,
    input  dcache_types_pkg::access_size_e  i_req_size,
    input  logic                            i_req_signed,
    input  mem_bus_pkg::addr_t              i_req_addr,
    input  mem_bus_pkg::word_t              i_req_wdata,
    output logic                            o_req_credit,
    output logic                            o_resp_valid,
    output mem_bus_pkg::word_t              o_resp_data,
    output dcache_types_pkg::exc_code_e     o_resp_exc,
    output logic                            o_mem_rvalid,
    output mem_bus_pkg::addr_t              o_mem_raddr,
    input  logic                            i_mem_rready,
    input  logic [(mem_bus_pkg::WORD_WIDTH << WORD_OFFSET_WIDTH)-1:0] i_mem_rdata,
    output logic                            o_mem_wvalid,
    output mem_bus_pkg::addr_t              o_mem_waddr,
    output logic [(mem_bus_pkg::WORD_WIDTH << WORD_OFFSET_WIDTH)-1:0] o_mem_wdata,
    input  logic                            i_mem_wready
);
    import dcache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - WORD_OFFSET_WIDTH - 2;

    // decode to execute
    logic                         dec_valid, dec_signed, dec_misaligned, pop_ready;
    mem_op_e                      dec_op;
    access_size_e                 dec_size;
    logic [INDEX_WIDTH-1:0]       dec_index;
    logic [TAG_WIDTH-1:0]         dec_tag;
    logic [WORD_OFFSET_WIDTH-1:0] dec_word_off;
    logic [1:0]                   dec_byte_off;
    word_t                        dec_wdata;

    // execute to result
    logic         acc_valid, acc_signed, acc_misaligned;
    mem_op_e      acc_op;
    access_size_e acc_size;
    logic [1:0]   acc_byte_off;
    word_t        acc_word;

    req_decode #(
        .INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH), .REQ_DEPTH(REQ_DEPTH)
    ) u_req_decode (
        .clk(clk), .rstn(rstn),
        .i_req_valid(i_req_valid), .i_req_op(i_req_op), .i_req_size(i_req_size),
        .i_req_signed(i_req_signed), .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
        .o_req_credit(o_req_credit), .i_pop_ready(pop_ready),
        .o_dec_valid(dec_valid), .o_dec_op(dec_op), .o_dec_size(dec_size),
        .o_dec_signed(dec_signed), .o_dec_index(dec_index), .o_dec_tag(dec_tag),
        .o_dec_word_off(dec_word_off), .o_dec_byte_off(dec_byte_off),
        .o_dec_wdata(dec_wdata), .o_dec_misaligned(dec_misaligned)
    );

    cache_exec #(
        .INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)
    ) u_cache_exec (
        .clk(clk), .rstn(rstn),
        .i_dec_valid(dec_valid), .i_dec_op(dec_op), .i_dec_size(dec_size),
        .i_dec_signed(dec_signed), .i_dec_index(dec_index), .i_dec_tag(dec_tag),
        .i_dec_word_off(dec_word_off), .i_dec_byte_off(dec_byte_off),
        .i_dec_wdata(dec_wdata), .i_dec_misaligned(dec_misaligned),
        .o_pop_ready(pop_ready),
        .o_acc_valid(acc_valid), .o_acc_op(acc_op), .o_acc_size(acc_size),
        .o_acc_signed(acc_signed), .o_acc_byte_off(acc_byte_off),
        .o_acc_misaligned(acc_misaligned), .o_acc_word(acc_word),
        .o_mem_rvalid(o_mem_rvalid), .o_mem_raddr(o_mem_raddr),
        .i_mem_rready(i_mem_rready), .i_mem_rdata(i_mem_rdata),
        .o_mem_wvalid(o_mem_wvalid), .o_mem_waddr(o_mem_waddr),
        .o_mem_wdata(o_mem_wdata), .i_mem_wready(i_mem_wready)
    );

    load_result u_load_result (
        .clk(clk), .rstn(rstn),
        .i_acc_valid(acc_valid), .i_acc_op(acc_op), .i_acc_size(acc_size),
        .i_acc_signed(acc_signed), .i_acc_byte_off(acc_byte_off),
        .i_acc_misaligned(acc_misaligned), .i_acc_word(acc_word),
        .o_resp_valid(o_resp_valid), .o_resp_data(o_resp_data), .o_resp_exc(o_resp_exc)
    );

endmodule

/* bench/dcache_asserts.sv */
`timescale 1ns/1ps

module dcache_asserts #(
    parameter int WORD_OFFSET_WIDTH = mem_bus_pkg::DEF_WORD_OFFSET_WIDTH
) (
    input logic               clk,
    input logic               rstn,
    input logic               i_rvalid,
    input mem_bus_pkg::addr_t i_raddr,
    input logic               i_rready,
    input logic               i_wvalid,
    input mem_bus_pkg::addr_t i_waddr,
    input logic [(mem_bus_pkg::WORD_WIDTH << WORD_OFFSET_WIDTH)-1:0] i_wdata,
    input logic               i_wready,
    input logic               i_resp_valid
);

    // refill request held until taken
    a_refill_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_rvalid && !i_rready |=> i_rvalid && $stable(i_raddr))
        else $error("refill request changed before it was accepted");

    a_wback_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_wvalid && !i_wready |=> i_wvalid && $stable(i_waddr) && $stable(i_wdata))
        else $error("write-back changed before it was accepted");

    a_one_side: assert property (@(posedge clk) disable iff (!rstn)
        !(i_rvalid && i_wvalid))
        else $error("refill and write-back active together");

    a_resp_pulse: assert property (@(posedge clk) disable iff (!rstn)
        i_resp_valid |=> !i_resp_valid)
        else $error("response valid high for two cycles in a row");

endmodule

bind dcache_top dcache_asserts #(.WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_dcache_asserts (
    .clk(clk), .rstn(rstn),
    .i_rvalid(o_mem_rvalid), .i_raddr(o_mem_raddr), .i_rready(i_mem_rready),
    .i_wvalid(o_mem_wvalid), .i_waddr(o_mem_waddr), .i_wdata(o_mem_wdata),
    .i_wready(i_mem_wready), .i_resp_valid(o_resp_valid)
);

/* bench/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    import dcache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int REQ_DEPTH  = DEF_REQ_DEPTH;
    localparam int LINE_WIDTH = WORD_WIDTH << DEF_WORD_OFFSET_WIDTH;
    localparam int NUM_REQS   = 400;

    typedef struct packed {
        mem_op_e      op;
        access_size_e size;
        logic         sign;
        addr_t        addr;
        word_t        wdata;
    } req_t;
    typedef logic [LINE_WIDTH-1:0] line_t;

    logic         clk = 1'b0;
    logic         rstn, req_valid, req_signed, req_credit, resp_valid;
    logic         mem_rvalid, mem_rready, mem_wvalid, mem_wready;
    mem_op_e      req_op;
    access_size_e req_size;
    addr_t        req_addr, mem_raddr, mem_waddr;
    word_t        req_wdata, resp_data;
    exc_code_e    resp_exc;
    line_t        mem_rdata, mem_wdata;

    word_t      mem_words [256];  // backing memory over a 1 KB window
    logic [7:0] ref_mem [1024];   // bytes as seen by all answered requests
    req_t       pend_q [$];
    int         seed = 30278;
    int         cycle, credits, issued, responses, credit_returns, mismatches, other_errors;

    dcache_top #(
        .INDEX_WIDTH(DEF_INDEX_WIDTH), .WORD_OFFSET_WIDTH(DEF_WORD_OFFSET_WIDTH),
        .REQ_DEPTH(REQ_DEPTH)
    ) u_dcache_top (
        .clk(clk), .rstn(rstn),
        .i_req_valid(req_valid), .i_req_op(req_op), .i_req_size(req_size),
        .i_req_signed(req_signed), .i_req_addr(req_addr), .i_req_wdata(req_wdata),
        .o_req_credit(req_credit), .o_resp_valid(resp_valid), .o_resp_data(resp_data),
        .o_resp_exc(resp_exc), .o_mem_rvalid(mem_rvalid), .o_mem_raddr(mem_raddr),
        .i_mem_rready(mem_rready), .i_mem_rdata(mem_rdata), .o_mem_wvalid(mem_wvalid),
        .o_mem_waddr(mem_waddr), .o_mem_wdata(mem_wdata), .i_mem_wready(mem_wready)
    );

    always #10 clk = ~clk;

    function automatic int size_bytes(access_size_e size);
        return (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
    endfunction

    function automatic bit is_misaligned(access_size_e size, addr_t addr);
        if (size == SIZE_HALF)
            return addr[0];
        return (size == SIZE_WORD) && (addr[1:0] != 2'b00);
    endfunction

    function automatic word_t expected_load(req_t r);
        word_t v;
        int    n;
        n = size_bytes(r.size);
        v = '0;
        for (int k = 0; k < n; k++)
            v[8*k +: 8] = ref_mem[r.addr[9:0] + 10'(k)];
        if (r.sign && v[8*n-1]) begin
            for (int k = n; k < 4; k++)
                v[8*k +: 8] = 8'hff;  // sign fill
        end
        return v;
    endfunction

    function automatic line_t ref_line(addr_t a);
        line_t l;
        for (int k = 0; k < 16; k++)
            l[8*k +: 8] = ref_mem[{a[9:4], k[3:0]}];
        return l;
    endfunction

    function automatic line_t mem_line(addr_t a);
        line_t l;
        for (int w = 0; w < 4; w++)
            l[32*w +: 32] = mem_words[{a[9:4], w[1:0]}];
        return l;
    endfunction

    task automatic check_resp_data(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("MISMATCH %s data expected %h actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_resp_exc(string name, exc_code_e exp, exc_code_e act);
        if (exp !== act) begin
            $display("MISMATCH %s exc expected %h actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_line(string name, line_t exp, line_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    // sender, memory ready and refill data driven 1 ns after the edge
    always @(posedge clk) begin
        word_t      r;
        req_t       nr;
        logic [3:0] off;
        #1;
        r          = $random(seed);
        rstn       = (cycle >= 7);
        mem_rready = (r[1:0] != 2'b00);  // random back-pressure
        mem_wready = (r[3:2] != 2'b00);
        mem_rdata  = mem_line(mem_raddr);
        req_valid  = 1'b0;
        if (cycle == 7)
            credits = REQ_DEPTH;
        if (rstn && req_credit) begin
            credits++;
            credit_returns++;
            if (credits > REQ_DEPTH) begin
                $display("credit count rose above the request queue depth");
                other_errors++;
            end
        end
        if (rstn && credits > 0 && issued < NUM_REQS && r[6:4] < 3'd5) begin
            nr.op   = (r[9:7] < 3'd3) ? OP_STORE : OP_LOAD;
            nr.size = (r[11:10] == 2'd3) ? SIZE_WORD : access_size_e'(r[11:10]);
            nr.sign = r[12];
            off     = r[19:16];
            if (r[15:13] != 3'd0) begin  // mostly aligned
                if (nr.size == SIZE_HALF) off[0] = 1'b0;
                if (nr.size == SIZE_WORD) off[1:0] = 2'b00;
            end
            // 16 lines on 4 sets with 4 tags each so ways get evicted
            nr.addr  = {22'd0, r[23:22], 2'b00, r[21:20], off};
            nr.wdata = $random(seed);
            req_op     = nr.op;
            req_size   = nr.size;
            req_signed = nr.sign;
            req_addr   = nr.addr;
            req_wdata  = nr.wdata;
            req_valid  = 1'b1;
            pend_q.push_back(nr);
            credits--;
            issued++;
        end
        cycle++;
    end

    // monitor samples mid-cycle where outputs are settled
    always @(negedge clk) begin
        req_t  pr;
        string name;
        if (rstn) begin
            if (mem_rvalid && mem_rready && (mem_raddr[3:0] != 4'd0 || mem_raddr[31:10] != '0)) begin
                $display("refill address %h is not a line address inside the window", mem_raddr);
                other_errors++;
            end
            if (mem_wvalid && mem_wready) begin
                if (mem_waddr[3:0] != 4'd0 || mem_waddr[31:10] != '0) begin
                    $display("write-back address %h is not a line address inside the window",
                             mem_waddr);
                    other_errors++;
                end
                check_line($sformatf("writeback %h", mem_waddr), ref_line(mem_waddr), mem_wdata);
                for (int w = 0; w < 4; w++)
                    mem_words[{mem_waddr[9:4], w[1:0]}] = mem_wdata[32*w +: 32];
            end
            if (resp_valid) begin
                if (pend_q.size() == 0) begin
                    $display("response arrived with no request outstanding");
                    other_errors++;
                end else begin
                    pr   = pend_q.pop_front();
                    name = $sformatf("req%0d %s @%h", responses, pr.op.name(), pr.addr);
                    if (is_misaligned(pr.size, pr.addr)) begin
                        check_resp_data(name, '0, resp_data);
                        check_resp_exc(name, EXC_ALE, resp_exc);
                    end else begin
                        check_resp_data(name, (pr.op == OP_STORE) ? '0 : expected_load(pr),
                                        resp_data);
                        check_resp_exc(name, EXC_NONE, resp_exc);
                        if (pr.op == OP_STORE) begin
                            for (int k = 0; k < size_bytes(pr.size); k++)
                                ref_mem[pr.addr[9:0] + 10'(k)] = pr.wdata[8*k +: 8];
                        end
                    end
                end
                responses++;
            end
        end
    end

    initial begin
        int idle;
        int last;
        int waited;
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_op     = OP_LOAD;
        req_size   = SIZE_BYTE;
        req_signed = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        mem_rready = 1'b0;
        mem_wready = 1'b0;
        mem_rdata  = '0;
        for (int i = 0; i < 256; i++) begin
            mem_words[i[7:0]] = (word_t'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
            for (int b = 0; b < 4; b++)
                ref_mem[{i[7:0], b[1:0]}] = mem_words[i[7:0]][8*b +: 8];
        end
        idle = 0;
        last = 0;
        while (responses < NUM_REQS && idle < 5000) begin
            @(posedge clk);
            idle = (responses != last) ? 0 : idle + 1;
            last = responses;
        end
        if (responses < NUM_REQS) begin
            $display("timeout: no response for 5000 cycles, %0d of %0d received",
                     responses, NUM_REQS);
            other_errors++;
        end
        waited = 0;
        while (credits != REQ_DEPTH && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (credit_returns != issued || pend_q.size() != 0) begin
            $display("%0d credits came back for %0d requests, %0d still pending",
                     credit_returns, issued, pend_q.size());
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* filelist.f */
hdl/dcache_types_pkg.sv
hdl/mem_bus_pkg.sv
hdl/req_decode.sv
hdl/cache_exec.sv
hdl/load_result.sv
hdl/dcache_top.sv
bench/dcache_asserts.sv
bench/tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_dcache
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJDIR)
